// ==== hw/plb_pkg.sv ====
package plb_pkg;

   // --------------------------------------------------
   // Bus widths
   // --------------------------------------------------

   // Byte address width on the bus
   localparam int ADDR_W = 16;

   // Width codes of the burst view
   localparam logic [2:0] W_BYTE  = 3'd0;
   localparam logic [2:0] W_HALF  = 3'd1;
   localparam logic [2:0] W_WORD  = 3'd2;
   localparam logic [2:0] W_DWORD = 3'd3;

   // --------------------------------------------------
   // Size field, two readings of the same four bits
   // --------------------------------------------------

   // Line reading: 0 single, 1/2/3 lines of 2/4/8 doublewords
   typedef struct packed {
      logic       burst;
      logic [2:0] line_code;
   } line_view_t;

   // Burst reading: 0 byte, 1 half, 2 word, 3 doubleword
   typedef struct packed {
      logic       burst;
      logic [2:0] width;
   } burst_view_t;

   typedef union packed {
      line_view_t  line_view;
      burst_view_t burst_view;
   } size_u;

   // Lane enables, lane 0 is the most significant byte
   typedef logic [0:7] be_t;

   // Request as captured on the req strobe
   typedef struct packed {
      logic              rnw;
      logic [ADDR_W-1:0] addr;
      size_u             size;
      be_t               be;
      // Beats minus one, bursts only
      logic [3:0]        len;
   } req_t;

endpackage

// ==== hw/slave_pkg.sv ====
package slave_pkg;

   // --------------------------------------------------
   // Per-beat command to the memory
   // --------------------------------------------------

   typedef struct packed {
      // Write strobe
      logic                          we;
      // Read strobe
      logic                          re;
      // Doubleword address
      logic [plb_pkg::ADDR_W-4:0]    dw_index;
      // Lanes to write
      plb_pkg::be_t                  be;
   } beat_t;

   // Beats per line code
   // Code 0 is a single transfer, unused codes act as single
   localparam logic [3:0] LINE_BEATS [8] = '{
      4'd1, 4'd2, 4'd4, 4'd8, 4'd1, 4'd1, 4'd1, 4'd1
   };

endpackage

// ==== hw/byte_enable_gen.sv ====
module byte_enable_gen (
   input  plb_pkg::size_u size,
   input  logic [2:0]     count,
   input  plb_pkg::be_t   be_in,
   output logic           burst,
   output logic           byte_w,
   output logic           half_w,
   output logic           word_w,
   output plb_pkg::be_t   be_out
);

   // --------------------------------------------------
   // Size decode
   // --------------------------------------------------

   // Burst bit is shared by both views
   assign burst = size.burst_view.burst;

   // Width flags straight from the burst view
   // Flags are raw, the burst bit qualifies them below
   assign byte_w = (size.burst_view.width == plb_pkg::W_BYTE);
   assign half_w = (size.burst_view.width == plb_pkg::W_HALF);
   assign word_w = (size.burst_view.width == plb_pkg::W_WORD);

   // --------------------------------------------------
   // Lane enables from position
   // --------------------------------------------------

   plb_pkg::be_t be_internal;
   logic         all_en;

   // Lines and doubleword bursts use every lane
   assign all_en = ~burst | (~byte_w & ~half_w & ~word_w);

   for (genvar g = 0; g < 8; g++) begin : g_lane
      localparam logic [2:0] LANE = 3'(g);

      logic word_hit;
      logic half_hit;
      logic byte_hit;

      // Quad chosen by position bit 2
      assign word_hit = word_w & (LANE[2] == count[2]);
      // Pair chosen by position bits 2 and 1
      assign half_hit = half_w & (LANE[2:1] == count[2:1]);
      // Exact lane
      assign byte_hit = byte_w & (LANE == count);

      assign be_internal[g] = all_en | word_hit | half_hit | byte_hit;
   end

   // --------------------------------------------------
   // Pass-through for single transfers
   // --------------------------------------------------

   // Size 0 keeps the master's own enables
   assign be_out = (|size) ? be_internal : be_in;

endmodule

// ==== hw/burst_seq.sv ====
module burst_seq #(
   parameter int ADDR_W = plb_pkg::ADDR_W
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              req,
   input  plb_pkg::req_t     cmd,
   input  plb_pkg::be_t      be_gen,
   input  logic              burst,
   input  logic              byte_w,
   input  logic              half_w,
   input  logic              word_w,
   output plb_pkg::size_u    size,
   output logic [2:0]        count,
   output plb_pkg::be_t      be_single,
   output slave_pkg::beat_t  beat,
   output logic              busy,
   output logic              wr_ack,
   output logic              rd_valid
);

   // --------------------------------------------------
   // Transfer state
   // --------------------------------------------------

   // Control
   logic              active;
   logic              rd_valid_q;

   // Payload of the latched command
   logic              rnw_q;
   logic [ADDR_W-1:0] addr_q;
   plb_pkg::size_u    size_q;
   plb_pkg::be_t      be_q;
   // Beats still to go after the current one
   logic [3:0]        left_q;

   logic              start;
   logic [3:0]        first_left;
   logic [ADDR_W-1:0] next_addr;

   // Master only raises req while idle
   assign start = req & ~busy;

   // Line view for non-bursts, len for bursts
   always_comb begin
      if (cmd.size.burst_view.burst) begin
         first_left = cmd.len;
      end else begin
         first_left = slave_pkg::LINE_BEATS[cmd.size.line_view.line_code] - 4'd1;
      end
   end

   // --------------------------------------------------
   // Address stepping
   // --------------------------------------------------

   always_comb begin
      logic [3:0]        step;
      logic [2:0]        lmask;
      logic [ADDR_W-4:0] wrap_mask;
      logic [ADDR_W-4:0] dw;
      logic [ADDR_W-4:0] dw_inc;

      // Byte step per burst width
      if (byte_w) begin
         step = 4'd1;
      end else if (half_w) begin
         step = 4'd2;
      end else if (word_w) begin
         step = 4'd4;
      end else begin
         step = 4'd8;
      end

      // Index bits that wrap inside the line
      case (size_q.line_view.line_code)
         3'd1:    lmask = 3'b001;
         3'd2:    lmask = 3'b011;
         3'd3:    lmask = 3'b111;
         default: lmask = 3'b000;
      endcase
      wrap_mask = (ADDR_W-3)'(lmask);
      dw        = addr_q[ADDR_W-1:3];
      dw_inc    = dw + 1'b1;

      if (burst) begin
         // Lane position wraps into the next doubleword
         next_addr = addr_q + ADDR_W'(step);
      end else begin
         // Stay inside the aligned line
         next_addr = {(dw & ~wrap_mask) | (dw_inc & wrap_mask), addr_q[2:0]};
      end
   end

   // --------------------------------------------------
   // Sequencing
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         active     <= 1'b0;
         rd_valid_q <= 1'b0;
      end else begin
         // Memory read is one cycle behind the strobe
         rd_valid_q <= beat.re;
         if (start) begin
            active <= 1'b1;
         end else if (active && left_q == 4'd0) begin
            active <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         rnw_q  <= cmd.rnw;
         addr_q <= cmd.addr[ADDR_W-1:0];
         size_q <= cmd.size;
         be_q   <= cmd.be;
         left_q <= first_left;
      end else if (active) begin
         addr_q <= next_addr;
         left_q <= left_q - 4'd1;
      end
   end

   // --------------------------------------------------
   // Outputs
   // --------------------------------------------------

   // To the enable generator
   assign size      = size_q;
   assign count     = addr_q[2:0];
   assign be_single = be_q;

   // One beat per active cycle
   assign beat.we       = active & ~rnw_q;
   assign beat.re       = active & rnw_q;
   assign beat.dw_index = addr_q[ADDR_W-1:3];
   assign beat.be       = be_gen;

   assign wr_ack   = beat.we;
   assign rd_valid = rd_valid_q;
   // Held through the last read data
   assign busy     = active | rd_valid_q;

endmodule

// ==== hw/lane_sram.sv ====
module lane_sram #(
   parameter int DEPTH = 64
) (
   input  logic             clk,
   input  slave_pkg::beat_t beat,
   input  logic [63:0]      wr_data,
   output logic [63:0]      rd_data
);

   // --------------------------------------------------
   // Storage
   // --------------------------------------------------

   localparam int IDX_W = $clog2(DEPTH);

   logic [63:0]      mem [DEPTH];
   logic [IDX_W-1:0] idx;

   // Upper index bits fall outside the array
   assign idx = beat.dw_index[IDX_W-1:0];

   // --------------------------------------------------
   // Write, one byte per lane
   // --------------------------------------------------

   // Lane 0 sits in bits 63:56
   always_ff @(posedge clk) begin
      if (beat.we) begin
         for (int i = 0; i < 8; i++) begin
            if (beat.be[i]) begin
               mem[idx][63-8*i -: 8] <= wr_data[63-8*i -: 8];
            end
         end
      end
   end

   // --------------------------------------------------
   // Registered read
   // --------------------------------------------------

   // Data follows the strobe by one cycle
   always_ff @(posedge clk) begin
      if (beat.re) begin
         rd_data <= mem[idx];
      end
   end

endmodule

// ==== hw/plb_slave_top.sv ====
module plb_slave_top #(
   parameter int ADDR_W    = plb_pkg::ADDR_W,
   parameter int MEM_DEPTH = 64
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          req,
   input  plb_pkg::req_t cmd,
   input  logic [63:0]   wr_data,
   output logic          busy,
   output logic          wr_ack,
   output logic          rd_valid,
   output logic [63:0]   rd_data
);

   // --------------------------------------------------
   // Internal nets
   // --------------------------------------------------

   plb_pkg::size_u   seq_size;
   logic [2:0]       lane_pos;
   plb_pkg::be_t     be_single;
   plb_pkg::be_t     be_gen;
   logic             burst;
   logic             byte_w;
   logic             half_w;
   logic             word_w;
   slave_pkg::beat_t beat;

   // Sequencer
   burst_seq #(
      .ADDR_W(ADDR_W)
   ) i_burst_seq (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .cmd       (cmd),
      .be_gen    (be_gen),
      .burst     (burst),
      .byte_w    (byte_w),
      .half_w    (half_w),
      .word_w    (word_w),
      .size      (seq_size),
      .count     (lane_pos),
      .be_single (be_single),
      .beat      (beat),
      .busy      (busy),
      .wr_ack    (wr_ack),
      .rd_valid  (rd_valid)
   );

   // Width flags and lane enables for the current beat
   byte_enable_gen i_byte_enable_gen (
      .size   (seq_size),
      .count  (lane_pos),
      .be_in  (be_single),
      .burst  (burst),
      .byte_w (byte_w),
      .half_w (half_w),
      .word_w (word_w),
      .be_out (be_gen)
   );

   // Memory
   lane_sram #(
      .DEPTH(MEM_DEPTH)
   ) i_lane_sram (
      .clk     (clk),
      .beat    (beat),
      .wr_data (wr_data),
      .rd_data (rd_data)
   );

endmodule

// ==== verif/plb_slave_checker.sv ====
module plb_slave_checker (
   input logic clk,
   input logic rst_n,
   input logic req,
   input logic busy,
   input logic wr_ack,
   input logic rd_valid
);

   // --------------------------------------------------
   // Request rule
   // --------------------------------------------------

   // Master waits for idle before a new request
   a_req_while_busy : assert property (
      @(posedge clk) disable iff (!rst_n) req |-> !busy
   ) else $error("req raised while the slave was busy");

   // --------------------------------------------------
   // Response strobes
   // --------------------------------------------------

   // A transfer is either all writes or all reads
   a_ack_and_valid : assert property (
      @(posedge clk) disable iff (!rst_n) !(wr_ack && rd_valid)
   ) else $error("wr_ack and rd_valid high in the same cycle");

   // Read data only inside a transfer
   a_valid_in_busy : assert property (
      @(posedge clk) disable iff (!rst_n) rd_valid |-> busy
   ) else $error("rd_valid seen while busy was low");

   // Idle right after reset
   a_idle_after_reset : assert property (
      @(posedge clk) $rose(rst_n) |-> !busy
   ) else $error("busy high in the first cycle after reset");

endmodule

// ==== verif/plb_slave_tb.sv ====
module plb_slave_tb;

   localparam int ADDR_W    = plb_pkg::ADDR_W;
   localparam int MEM_DEPTH = 64;

   // One row of the stimulus table
   typedef struct {
      string         name;
      plb_pkg::req_t cmd;
      int            beats;
   } entry_t;

   // --------------------------------------------------
   // DUT signals
   // --------------------------------------------------

   logic          clk;
   logic          rst_n;
   logic          req;
   plb_pkg::req_t cmd;
   logic [63:0]   wr_data;
   logic          busy;
   logic          wr_ack;
   logic          rd_valid;
   logic [63:0]   rd_data;

   // Stimulus table, byte-lane reference memory, run limit
   entry_t        tests[$];
   logic [7:0]    ref_mem [MEM_DEPTH*8];
   int            cycles;
   int            cycle_limit;

   plb_slave_top #(
      .ADDR_W    (ADDR_W),
      .MEM_DEPTH (MEM_DEPTH)
   ) i_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .cmd      (cmd),
      .wr_data  (wr_data),
      .busy     (busy),
      .wr_ack   (wr_ack),
      .rd_valid (rd_valid),
      .rd_data  (rd_data)
   );

   // Protocol assertions on the top level
   bind plb_slave_top plb_slave_checker i_checker (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .busy     (busy),
      .wr_ack   (wr_ack),
      .rd_valid (rd_valid)
   );

   always #50 clk = ~clk;

   // Run limit is set once the table is built
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("sim failed");
         $fatal(1, "cycle limit reached");
      end
   end

   // --------------------------------------------------
   // Compare tasks
   // --------------------------------------------------

   task automatic check_word(string name, logic [63:0] expected, logic [63:0] actual);
      if (actual !== expected) begin
         $display("Error %s: expected %h, actual %h", name, expected, actual);
         $display("sim failed");
         $fatal(1, "read data mismatch");
      end
   endtask

   task automatic check_count(string name, int expected, int actual);
      if (actual != expected) begin
         $display("Error %s: expected %0d, actual %0d", name, expected, actual);
         $display("sim failed");
         $fatal(1, "count mismatch");
      end
   endtask

   // --------------------------------------------------
   // Reference rules
   // --------------------------------------------------

   function automatic plb_pkg::req_t make_cmd(logic rnw, logic [ADDR_W-1:0] addr, logic burst,
                                              logic [2:0] code, plb_pkg::be_t be,
                                              logic [3:0] len);
      plb_pkg::req_t c;
      c = '0;
      c.rnw                   = rnw;
      c.addr                  = addr;
      c.size.line_view.burst  = burst;
      // Same bits serve as line code or width code
      c.size.line_view.line_code = code;
      c.be                    = be;
      c.len                   = len;
      return c;
   endfunction

   function automatic void add_test(string name, plb_pkg::req_t c, int beats);
      entry_t e;
      e.name  = name;
      e.cmd   = c;
      e.beats = beats;
      tests.push_back(e);
   endfunction

   // Lanes of one beat at lane position pos
   function automatic plb_pkg::be_t lanes_for(plb_pkg::req_t c, logic [2:0] pos);
      plb_pkg::be_t lanes;
      int           span;
      int           base;
      // Single transfer keeps the master's enables
      if (c.size == '0) begin
         return c.be;
      end
      // Line transfer writes whole doublewords
      if (!c.size.burst_view.burst) begin
         return 8'hff;
      end
      // Aligned group of 1, 2, 4 or 8 lanes around pos
      span = 1 << c.size.burst_view.width;
      base = int'(pos) & ~(span - 1);
      for (int i = 0; i < 8; i++) begin
         lanes[i] = (i >= base) && (i < base + span);
      end
      return lanes;
   endfunction

   // Byte address of the next beat
   function automatic logic [ADDR_W-1:0] step_addr(plb_pkg::req_t c, logic [ADDR_W-1:0] a);
      int n;
      int dw;
      int base;
      if (c.size.burst_view.burst) begin
         return a + (ADDR_W'(1) << c.size.burst_view.width);
      end
      // Line wraps inside its aligned block of n doublewords
      n    = 1 << c.size.line_view.line_code;
      dw   = int'(a >> 3);
      base = dw - (dw % n);
      return ADDR_W'(((base + (dw + 1) % n) << 3) | int'(a[2:0]));
   endfunction

   // --------------------------------------------------
   // One table entry
   // --------------------------------------------------

   task automatic run_test(entry_t e);
      logic [ADDR_W-1:0] a;
      plb_pkg::be_t      lanes;
      logic [63:0]       data;
      logic [63:0]       expected;
      int                dw;
      int                seen;
      int                busy_cycles;
      a           = e.cmd.addr;
      seen        = 0;
      busy_cycles = 0;
      @(negedge clk);
      req = 1'b1;
      cmd = e.cmd;
      @(negedge clk);
      req = 1'b0;
      // Beats follow until busy drops
      while (busy) begin
         busy_cycles = busy_cycles + 1;
         dw = int'(a >> 3) % MEM_DEPTH;
         if (wr_ack) begin
            data    = {$urandom, $urandom};
            wr_data = data;
            lanes   = lanes_for(e.cmd, a[2:0]);
            for (int i = 0; i < 8; i++) begin
               if (lanes[i]) begin
                  ref_mem[dw*8+i] = data[63-8*i -: 8];
               end
            end
            a    = step_addr(e.cmd, a);
            seen = seen + 1;
         end
         if (rd_valid) begin
            // Lane 0 in the top byte
            for (int i = 0; i < 8; i++) begin
               expected[63-8*i -: 8] = ref_mem[dw*8+i];
            end
            check_word(e.name, expected, rd_data);
            a    = step_addr(e.cmd, a);
            seen = seen + 1;
         end
         @(negedge clk);
      end
      check_count({e.name, " beats"}, e.beats, seen);
      // Busy spans the beats plus one cycle of read latency
      check_count({e.name, " busy cycles"}, e.beats + int'(e.cmd.rnw), busy_cycles);
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------

   initial begin
      void'($urandom(32'hd1be_1b82));
      clk         = 1'b0;
      rst_n       = 1'b0;
      req         = 1'b0;
      cmd         = '0;
      wr_data     = '0;
      cycles      = 0;
      cycle_limit = 0;

      // Fill doublewords 0 to 31 so every later read is known
      add_test("init_lo", make_cmd(1'b0, 16'h0000, 1'b1, 3'd3, '0, 4'd15), 16);
      add_test("init_hi", make_cmd(1'b0, 16'h0080, 1'b1, 3'd3, '0, 4'd15), 16);
      // Sparse single writes into doubleword 2
      add_test("single_wr_a", make_cmd(1'b0, 16'h0010, 1'b0, 3'd0, 8'b1010_0001, 4'd0), 1);
      add_test("single_wr_b", make_cmd(1'b0, 16'h0010, 1'b0, 3'd0, 8'b0100_0100, 4'd0), 1);
      add_test("single_rd", make_cmd(1'b1, 16'h0010, 1'b0, 3'd0, '0, 4'd0), 1);
      // Line of 4 from the third doubleword of its line wraps 6 7 4 5
      add_test("line4_wr_wrap", make_cmd(1'b0, 16'h0030, 1'b0, 3'd2, '0, 4'd0),
               int'(slave_pkg::LINE_BEATS[2]));
      add_test("line8_rd", make_cmd(1'b1, 16'h0000, 1'b0, 3'd3, '0, 4'd0),
               int'(slave_pkg::LINE_BEATS[3]));
      // Byte burst from lane 5 of doubleword 8 into doubleword 9
      add_test("byte_burst_wr", make_cmd(1'b0, 16'h0045, 1'b1, 3'd0, '0, 4'd9), 10);
      add_test("byte_rd_lo", make_cmd(1'b1, 16'h0040, 1'b0, 3'd0, '0, 4'd0), 1);
      add_test("byte_rd_hi", make_cmd(1'b1, 16'h0048, 1'b0, 3'd0, '0, 4'd0), 1);
      // Unaligned halfword and word bursts
      add_test("half_burst_wr", make_cmd(1'b0, 16'h0063, 1'b1, 3'd1, '0, 4'd4), 5);
      add_test("word_burst_wr", make_cmd(1'b0, 16'h0086, 1'b1, 3'd2, '0, 4'd2), 3);
      add_test("half_rd", make_cmd(1'b1, 16'h0060, 1'b1, 3'd3, '0, 4'd1), 2);
      add_test("word_rd", make_cmd(1'b1, 16'h0080, 1'b1, 3'd3, '0, 4'd1), 2);
      // Six sequential doublewords
      add_test("dword_rd6", make_cmd(1'b1, 16'h0088, 1'b1, 3'd3, '0, 4'd5), 6);

      // Beats plus 4 per entry plus margin
      cycle_limit = 20;
      foreach (tests[k]) begin
         cycle_limit = cycle_limit + tests[k].beats + 4;
      end

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      foreach (tests[k]) begin
         run_test(tests[k]);
      end

      @(negedge clk);
      $display("sim passed");
      $finish;
   end

endmodule

// ==== compile.f ====
hw/plb_pkg.sv
hw/slave_pkg.sv
hw/byte_enable_gen.sv
hw/burst_seq.sv
hw/lane_sram.sv
hw/plb_slave_top.sv
verif/plb_slave_checker.sv
verif/plb_slave_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

# Build the simulation binary
verilator --binary --timing --assert -Wno-fatal \
   -f compile.f --top-module plb_slave_tb -Mdir obj_dir

# The run may stop on a fatal check, the output decides
sim_out=$(./obj_dir/Vplb_slave_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "sim passed"; then
   exit 0
else
   exit 1
fi
